// File: dwc_addr_downconv.f
+incdir+hdl
hdl/dwc_pkg.sv
hdl/decoded_cmd_if.sv
hdl/burst_length_calc.sv
hdl/cmd_queue.sv
hdl/burst_splitter.sv
hdl/dwc_addr_downconv.sv
tests/dwc_checker.sv
tests/tb_dwc_addr_downconv.sv

// File: run_sim.sh
#!/bin/bash
set -o pipefail

verilator --binary --timing --assert -Wno-fatal \
   -f dwc_addr_downconv.f --top-module tb_dwc_addr_downconv \
   -Mdir obj_dir -o sim_tb \
   && ./obj_dir/sim_tb 2>&1 | tee sim.log \
   && ! grep -q "ERRORS FOUND" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: tests/tb_dwc_addr_downconv.sv
`include "dwc_defines.svh"

module tb_dwc_addr_downconv;

   import dwc_pkg::*;

   localparam int num_rows = 12;

   // stall mode 0 none, 1 random slave ready, 2 also nearly-full pulses
   typedef struct packed {
      id_t        id;
      addr_t      addr;
      alen_t      alen;
      size_t      size;
      logic [1:0] mode;
      logic [5:0] pieces;
   } row_t;

   row_t       rows [num_rows];
   logic       ACLK;
   logic       sysReset;
   logic       mst_avalid, mst_aready, slv_avalid, slv_aready;
   logic       cmd_fifo_nearly_full, cmd_we, cmd_last, end_of_test;
   id_t        mst_aid, slv_aid, cmd_id;
   addr_t      mst_aaddr, slv_aaddr;
   alen_t      mst_alen, slv_alen;
   size_t      mst_asize, slv_asize;
   logic [1:0] mst_aburst, slv_aburst, stall_mode;
   addr_lo_t   cmd_addr_lo;
   beats_t     cmd_beats;
   int         exp_pieces, error_count, last_count;

   dwc_addr_downconv i_dwc_addr_downconv (.*);

   dwc_checker i_dwc_checker (.*);

   initial
   begin
      ACLK = 1'b0;
      forever #4 ACLK = ~ACLK;
   end

   // one last command per finished request
   always @(negedge ACLK)
   begin
      if (sysReset && cmd_we && cmd_last)
         last_count <= last_count + 1;
   end

   //////////////////////////////////////////////////
   // slave side and command FIFO level
   //////////////////////////////////////////////////

   initial
   begin
      void'($urandom(32'hfd5ecd4f));
      slv_aready           = 1'b0;
      cmd_fifo_nearly_full = 1'b0;
      forever
      begin
         @(posedge ACLK);
         slv_aready           <= (stall_mode == 0) || ($urandom % 2 == 0);
         cmd_fifo_nearly_full <= (stall_mode == 2) && ($urandom % 5 == 0);
      end
   end

   initial
   begin
      sysReset    = 1'b0;
      mst_avalid  = 1'b0;
      mst_aid     = '0;
      mst_aaddr   = '0;
      mst_alen    = '0;
      mst_asize   = '0;
      mst_aburst  = 2'b01;
      stall_mode  = 2'd0;
      exp_pieces  = 0;
      end_of_test = 1'b0;
      last_count  = 0;
      //          id     addr       alen    size  mode  pieces
      rows[0]  = '{2'd0, 20'h01000, 8'd3,   3'd2, 2'd0, 6'd1};
      rows[1]  = '{2'd1, 20'h01104, 8'd0,   3'd1, 2'd0, 6'd1};
      rows[2]  = '{2'd2, 20'h02000, 8'd3,   3'd3, 2'd0, 6'd1};
      rows[3]  = '{2'd3, 20'h03000, 8'd15,  3'd3, 2'd0, 6'd2};
      rows[4]  = '{2'd0, 20'h04006, 8'd11,  3'd3, 2'd0, 6'd2};
      rows[5]  = '{2'd1, 20'h06000, 8'd63,  3'd3, 2'd1, 6'd8};
      rows[6]  = '{2'd1, 20'h0d000, 8'd255, 3'd3, 2'd2, 6'd32};
      rows[7]  = '{2'd3, 20'h07002, 8'd20,  3'd2, 2'd2, 6'd2};
      rows[8]  = '{2'd0, 20'h08000, 8'd31,  3'd3, 2'd2, 6'd4};
      rows[9]  = '{2'd2, 20'h0a003, 8'd4,   3'd0, 2'd2, 6'd1};
      rows[10] = '{2'd3, 20'h0c00c, 8'd16,  3'd3, 2'd2, 6'd3};
      rows[11] = '{2'd0, 20'h0f100, 8'd1,   3'd2, 2'd0, 6'd1};
      repeat (10) @(posedge ACLK);
      sysReset <= 1'b1;
      repeat (2) @(posedge ACLK);
      foreach (rows[i])
      begin
         mst_avalid <= 1'b1;
         mst_aid    <= rows[i].id;
         mst_aaddr  <= rows[i].addr;
         mst_alen   <= rows[i].alen;
         mst_asize  <= rows[i].size;
         exp_pieces <= int'(rows[i].pieces);
         stall_mode <= rows[i].mode;
         @(negedge ACLK);
         while (!mst_aready)
            @(negedge ACLK);
         @(posedge ACLK);
      end
      mst_avalid <= 1'b0;
      while (last_count < num_rows)
         @(posedge ACLK);
      repeat (4) @(posedge ACLK);
      end_of_test <= 1'b1;
      @(negedge ACLK);
      @(posedge ACLK);
      $display("rows: %0d, errors: %0d", num_rows, error_count);
      if (error_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // watchdog, scaled by the longest split in the table
   initial
   begin
      int max_pieces;
      int limit;
      @(posedge sysReset);
      max_pieces = 0;
      foreach (rows[i])
         if (int'(rows[i].pieces) > max_pieces)
            max_pieces = int'(rows[i].pieces);
      limit = num_rows * (max_pieces * 40 + 50);
      repeat (limit) @(posedge ACLK);
      $display("timeout: the test did not finish within %0d cycles", limit);
      $display("rows: %0d, errors: %0d", num_rows, error_count);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: tests/dwc_checker.sv
`include "dwc_defines.svh"

module dwc_checker (
   input  logic                ACLK,
   input  logic                sysReset,
   input  logic                mst_avalid,
   input  logic                mst_aready,
   input  dwc_pkg::id_t        mst_aid,
   input  dwc_pkg::addr_t      mst_aaddr,
   input  dwc_pkg::alen_t      mst_alen,
   input  dwc_pkg::size_t      mst_asize,
   input  logic                slv_avalid,
   input  logic                slv_aready,
   input  dwc_pkg::id_t        slv_aid,
   input  dwc_pkg::addr_t      slv_aaddr,
   input  dwc_pkg::alen_t      slv_alen,
   input  dwc_pkg::size_t      slv_asize,
   input  logic [1:0]          slv_aburst,
   input  logic                cmd_fifo_nearly_full,
   input  logic                cmd_we,
   input  dwc_pkg::id_t        cmd_id,
   input  dwc_pkg::addr_lo_t   cmd_addr_lo,
   input  dwc_pkg::beats_t     cmd_beats,
   input  logic                cmd_last,
   input  int                  exp_pieces,
   input  logic                end_of_test,
   output int                  error_count
);

   import dwc_pkg::*;

   typedef struct packed {
      id_t   id;
      addr_t addr;
      alen_t alen;
      size_t size;
      logic  last;
   } piece_t;

   piece_t      exp_q [$];
   piece_t      head;
   logic [32:0] held;
   logic        was_waiting;
   logic        prev_valid;
   logic        prev_hs;
   logic        prev_nf;
   logic        end_seen;
   int          occupancy;

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic report(input string what);
      $display("%0t: %s", $time, what);
      error_count++;
   endtask

   // expected slave pieces of one accepted master request
   task automatic queue_pieces();
      int unsigned rem;
      int unsigned n;
      int          count;
      size_t       ssize;
      addr_t       a;
      ssize = (mst_asize > `DWC_SLV_SIZE) ? size_t'(`DWC_SLV_SIZE) : mst_asize;
      rem   = (int'(mst_alen) + 1) << (mst_asize - ssize);
      a     = mst_aaddr;
      count = 0;
      while (rem != 0)
      begin
         n = (rem > `DWC_MAX_SLV_BEATS) ? `DWC_MAX_SLV_BEATS : rem;
         exp_q.push_back(piece_t'{mst_aid, a, alen_t'(n - 1), ssize, rem == n});
         a   = ((a >> ssize) << ssize) + addr_t'(n << ssize);
         rem = rem - n;
         count++;
      end
      if (count != exp_pieces)
         report($sformatf("request with id %0d splits into %0d pieces, table says %0d",
                          mst_aid, count, exp_pieces));
   endtask

   //////////////////////////////////////////////////
   // sampled mid-cycle, inputs move on rising edges
   //////////////////////////////////////////////////

   always @(negedge ACLK)
   begin
      if (!sysReset)
      begin
         exp_q.delete();
         error_count = 0;
         occupancy   = 0;
         was_waiting = 1'b0;
         prev_valid  = 1'b0;
         prev_hs     = 1'b0;
         prev_nf     = 1'b0;
         end_seen    = 1'b0;
      end
      else
      begin
         compare_field("mst_aready", mst_aready, occupancy < `DWC_QUEUE_DEPTH);
         compare_field("cmd_we", cmd_we, slv_avalid && slv_aready);
         if (was_waiting)
         begin
            compare_field("slv_avalid", slv_avalid, 1'b1);
            compare_field("{slv_aid,slv_aaddr,slv_alen,slv_asize}",
                          {slv_aid, slv_aaddr, slv_alen, slv_asize}, held);
         end
         if (slv_avalid && (!prev_valid || prev_hs) && prev_nf)
            report("slv_avalid raised while the command FIFO was nearly full");
         if (slv_avalid && exp_q.size() == 0)
            report("slave request with no master request behind it");
         else if (slv_avalid && slv_aready)
         begin
            head = exp_q.pop_front();
            compare_field("slv_aid", slv_aid, (`DWC_READ_INTERLEAVE != 0) ? head.id : '0);
            compare_field("slv_aaddr", slv_aaddr, head.addr);
            compare_field("slv_alen", slv_alen, head.alen);
            compare_field("slv_asize", slv_asize, head.size);
            compare_field("slv_aburst", slv_aburst, 2'b01);
            compare_field("cmd_id", cmd_id, head.id);
            compare_field("cmd_addr_lo", cmd_addr_lo, head.addr[5:0]);
            compare_field("cmd_beats", cmd_beats, int'(head.alen) + 1);
            compare_field("cmd_last", cmd_last, head.last);
            if (head.last)
               occupancy--;
         end
         if (mst_avalid && mst_aready)
         begin
            queue_pieces();
            occupancy++;
         end
         if (end_of_test && !end_seen && exp_q.size() != 0)
            report($sformatf("%0d expected slave pieces never came out", exp_q.size()));
         end_seen    = end_of_test;
         was_waiting = slv_avalid && !slv_aready;
         held        = {slv_aid, slv_aaddr, slv_alen, slv_asize};
         prev_valid  = slv_avalid;
         prev_hs     = slv_avalid && slv_aready;
         prev_nf     = cmd_fifo_nearly_full;
      end
   end

endmodule

// File: hdl/dwc_addr_downconv.sv
`include "dwc_defines.svh"

module dwc_addr_downconv (
   input  logic                ACLK,
   input  logic                sysReset,

   // master address channel
   input  logic                mst_avalid,
   output logic                mst_aready,
   input  dwc_pkg::id_t        mst_aid,
   input  dwc_pkg::addr_t      mst_aaddr,
   input  dwc_pkg::alen_t      mst_alen,
   input  dwc_pkg::size_t      mst_asize,
   input  logic [1:0]          mst_aburst,

   // slave address channel
   output logic                slv_avalid,
   input  logic                slv_aready,
   output dwc_pkg::id_t        slv_aid,
   output dwc_pkg::addr_t      slv_aaddr,
   output dwc_pkg::alen_t      slv_alen,
   output dwc_pkg::size_t      slv_asize,
   output logic [1:0]          slv_aburst,

   // data path command FIFO
   input  logic                cmd_fifo_nearly_full,
   output logic                cmd_we,
   output dwc_pkg::id_t        cmd_id,
   output dwc_pkg::addr_lo_t   cmd_addr_lo,
   output dwc_pkg::beats_t     cmd_beats,
   output logic                cmd_last
);

   import dwc_pkg::*;

   decoded_cmd_if dec_q ();
   decoded_cmd_if q_spl ();

   //////////////////////////////////////////////////
   // decoder, queue, splitter
   //////////////////////////////////////////////////

   burst_length_calc i_burst_length_calc (
      .ACLK        (ACLK),
      .sysReset    (sysReset),
      .mst_avalid  (mst_avalid),
      .mst_aready  (mst_aready),
      .mst_aid     (mst_aid),
      .mst_aaddr   (mst_aaddr),
      .mst_alen    (mst_alen),
      .mst_asize   (mst_asize),
      .mst_aburst  (mst_aburst),
      .req         (dec_q)
   );

   cmd_queue i_cmd_queue (
      .ACLK        (ACLK),
      .sysReset    (sysReset),
      .wr          (dec_q),
      .rd          (q_spl)
   );

   burst_splitter i_burst_splitter (
      .ACLK                 (ACLK),
      .sysReset             (sysReset),
      .req                  (q_spl),
      .slv_avalid           (slv_avalid),
      .slv_aready           (slv_aready),
      .slv_aid              (slv_aid),
      .slv_aaddr            (slv_aaddr),
      .slv_alen             (slv_alen),
      .slv_asize            (slv_asize),
      .slv_aburst           (slv_aburst),
      .cmd_fifo_nearly_full (cmd_fifo_nearly_full),
      .cmd_we               (cmd_we),
      .cmd_id               (cmd_id),
      .cmd_addr_lo          (cmd_addr_lo),
      .cmd_beats            (cmd_beats),
      .cmd_last             (cmd_last)
   );

endmodule

// File: hdl/burst_splitter.sv
`include "dwc_defines.svh"

module burst_splitter (
   input  logic                ACLK,
   input  logic                sysReset,
   decoded_cmd_if.snk          req,
   output logic                slv_avalid,
   input  logic                slv_aready,
   output dwc_pkg::id_t        slv_aid,
   output dwc_pkg::addr_t      slv_aaddr,
   output dwc_pkg::alen_t      slv_alen,
   output dwc_pkg::size_t      slv_asize,
   output logic [1:0]          slv_aburst,
   input  logic                cmd_fifo_nearly_full,
   output logic                cmd_we,
   output dwc_pkg::id_t        cmd_id,
   output dwc_pkg::addr_lo_t   cmd_addr_lo,
   output dwc_pkg::beats_t     cmd_beats,
   output logic                cmd_last
);

   import dwc_pkg::*;

   localparam beats_t max_beats = beats_t'(`DWC_MAX_SLV_BEATS);

   splitter_state_e state;
   beats_t          remaining;
   logic            last_piece;
   id_t             cur_id;

   beats_t head_piece;
   beats_t next_piece;
   beats_t cur_beats;
   addr_t  align_mask;
   addr_t  next_addr;
   logic   slv_hs;
   logic   load_first;
   logic   load_next;

   // one slave burst never exceeds the max length
   function automatic beats_t piece_of(input beats_t total);
      beats_t piece;
      piece = (total > max_beats) ? max_beats : total;
      return piece;
   endfunction

   assign head_piece = piece_of(req.beats);
   assign next_piece = piece_of(remaining);
   assign cur_beats  = beats_t'(slv_alen) + beats_t'(1);

   //////////////////////////////////////////////////
   // address of the following piece
   //////////////////////////////////////////////////

   assign align_mask = {`DWC_ADDR_WIDTH{1'b1}} << slv_asize;
   assign next_addr  = (slv_aaddr & align_mask) + (addr_t'(cur_beats) << slv_asize);

   assign slv_hs     = slv_avalid & slv_aready;
   assign load_first = (state == WAIT_REQ) && req.valid && !cmd_fifo_nearly_full;
   assign load_next  = (state == SEND_BURST) && slv_hs && !last_piece;

   // pop the head with the last piece
   assign req.ready  = (state == SEND_BURST) && slv_hs && last_piece;

   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         state      <= WAIT_REQ;
         slv_avalid <= 1'b0;
         remaining  <= '0;
         last_piece <= 1'b0;
      end
      else
      begin
         case (state)
            WAIT_REQ:
            begin
               if (load_first)
               begin
                  remaining  <= req.beats - head_piece;
                  last_piece <= (req.beats == head_piece);
                  slv_avalid <= 1'b1;
                  state      <= SEND_BURST;
               end
            end
            SEND_BURST:
            begin
               if (slv_hs && last_piece)
               begin
                  slv_avalid <= 1'b0;
                  state      <= WAIT_REQ;
               end
               else if (load_next)
               begin
                  remaining  <= remaining - next_piece;
                  last_piece <= (remaining == next_piece);
                  // a raised valid stays, a new one waits for room
                  slv_avalid <= !cmd_fifo_nearly_full;
               end
               else if (!slv_avalid && !cmd_fifo_nearly_full)
                  slv_avalid <= 1'b1;
            end
            default:
               state <= WAIT_REQ;
         endcase
      end
   end

   always_ff @(posedge ACLK)
   begin
      if (load_first)
      begin
         slv_aaddr <= req.addr;
         slv_alen  <= alen_t'(head_piece - beats_t'(1));
         slv_asize <= req.size;
         cur_id    <= req.id;
      end
      else if (load_next)
      begin
         slv_aaddr <= next_addr;
         slv_alen  <= alen_t'(next_piece - beats_t'(1));
      end
   end

   assign slv_aid    = (`DWC_READ_INTERLEAVE != 0) ? cur_id : '0;
   assign slv_aburst = `DWC_BURST_INCR;

   //////////////////////////////////////////////////
   // command record for the data path
   //////////////////////////////////////////////////

   assign cmd_we      = slv_hs;
   assign cmd_id      = cur_id;
   assign cmd_addr_lo = slv_aaddr[5:0];
   assign cmd_beats   = cur_beats;
   assign cmd_last    = last_piece;

   a_valid_held: assert property (@(posedge ACLK) disable iff (!sysReset)
      slv_avalid && !slv_aready |=> slv_avalid);

   a_fields_stable: assert property (@(posedge ACLK) disable iff (!sysReset)
      slv_avalid && !slv_aready |=> $stable({slv_aid, slv_aaddr, slv_alen, slv_asize}));

endmodule

// File: hdl/cmd_queue.sv
`include "dwc_defines.svh"

module cmd_queue (
   input  logic        ACLK,
   input  logic        sysReset,
   decoded_cmd_if.snk  wr,
   decoded_cmd_if.src  rd
);

   import dwc_pkg::*;

   localparam int ptr_w = $clog2(`DWC_QUEUE_DEPTH);
   localparam logic [ptr_w:0] full_count = `DWC_QUEUE_DEPTH;

   id_t    id_mem    [`DWC_QUEUE_DEPTH];
   addr_t  addr_mem  [`DWC_QUEUE_DEPTH];
   beats_t beats_mem [`DWC_QUEUE_DEPTH];
   size_t  size_mem  [`DWC_QUEUE_DEPTH];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             wr_hs;
   logic             rd_hs;

   assign wr.ready = (count != full_count);
   assign rd.valid = (count != '0);
   assign wr_hs    = wr.valid & wr.ready;
   assign rd_hs    = rd.valid & rd.ready;

   // head entry
   assign rd.id    = id_mem[rd_ptr];
   assign rd.addr  = addr_mem[rd_ptr];
   assign rd.beats = beats_mem[rd_ptr];
   assign rd.size  = size_mem[rd_ptr];

   always_ff @(posedge ACLK)
   begin
      if (wr_hs)
      begin
         id_mem[wr_ptr]    <= wr.id;
         addr_mem[wr_ptr]  <= wr.addr;
         beats_mem[wr_ptr] <= wr.beats;
         size_mem[wr_ptr]  <= wr.size;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge ACLK or negedge sysReset)
   begin
      if (!sysReset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_hs)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_hs)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_hs, rd_hs})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge ACLK) disable iff (!sysReset)
      count <= full_count);

endmodule

// File: hdl/burst_length_calc.sv
`include "dwc_defines.svh"

module burst_length_calc (
   input  logic              ACLK,
   input  logic              sysReset,
   input  logic              mst_avalid,
   output logic              mst_aready,
   input  dwc_pkg::id_t      mst_aid,
   input  dwc_pkg::addr_t    mst_aaddr,
   input  dwc_pkg::alen_t    mst_alen,
   input  dwc_pkg::size_t    mst_asize,
   input  logic [1:0]        mst_aburst,
   decoded_cmd_if.src        req
);

   import dwc_pkg::*;

   beats_t len_beats;
   size_t  size_diff;

   assign len_beats = beats_t'(mst_alen) + beats_t'(1);
   assign size_diff = mst_asize - size_t'(`DWC_SLV_SIZE);

   // wider master beats become several slave beats
   always_comb
   begin
      if (mst_asize > size_t'(`DWC_SLV_SIZE))
      begin
         req.beats = len_beats << size_diff;
         req.size  = size_t'(`DWC_SLV_SIZE);
      end
      else
      begin
         req.beats = len_beats;
         req.size  = mst_asize;
      end
   end

   assign req.valid  = mst_avalid;
   assign req.id     = mst_aid;
   assign req.addr   = mst_aaddr;
   assign mst_aready = req.ready;

   //////////////////////////////////////////////////
   // master request checks
   //////////////////////////////////////////////////

   a_incr_only: assert property (@(posedge ACLK) disable iff (!sysReset)
      mst_avalid && mst_aready |-> mst_aburst == `DWC_BURST_INCR);

   a_size_max: assert property (@(posedge ACLK) disable iff (!sysReset)
      mst_avalid && mst_aready |-> mst_asize <= size_t'(`DWC_MST_SIZE_MAX));

endmodule

// File: hdl/decoded_cmd_if.sv
// one decoded master request, valid/ready handshake
interface decoded_cmd_if;

   logic             valid;
   logic             ready;
   dwc_pkg::id_t     id;
   dwc_pkg::addr_t   addr;
   dwc_pkg::beats_t  beats;
   dwc_pkg::size_t   size;

   modport src (
      output valid,
      output id,
      output addr,
      output beats,
      output size,
      input  ready
   );

   modport snk (
      input  valid,
      input  id,
      input  addr,
      input  beats,
      input  size,
      output ready
   );

endinterface

// File: hdl/dwc_pkg.sv
`include "dwc_defines.svh"

package dwc_pkg;

   //////////////////////////////////////////////////
   // vector types
   //////////////////////////////////////////////////

   typedef logic [`DWC_ADDR_WIDTH-1:0] addr_t;
   typedef logic [`DWC_ID_WIDTH-1:0]   id_t;

   // AXI size code
   typedef logic [2:0] size_t;

   // AXI length field, beats minus one
   typedef logic [7:0] alen_t;

   // slave beats of a whole master burst, up to 256 x 2
   typedef logic [9:0] beats_t;

   // low address bits for the data path, 64-byte window
   typedef logic [5:0] addr_lo_t;

   //////////////////////////////////////////////////
   // splitter FSM
   //////////////////////////////////////////////////

   typedef enum logic [0:0] {
      WAIT_REQ,
      SEND_BURST
   } splitter_state_e;

endpackage

// File: hdl/dwc_defines.svh
`ifndef DWC_DEFINES_SVH
`define DWC_DEFINES_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

`define DWC_ADDR_WIDTH      20
`define DWC_ID_WIDTH        2

//////////////////////////////////////////////////
// sizes and burst limits
//////////////////////////////////////////////////

// log2 of slave bytes per beat, 32-bit slave
`define DWC_SLV_SIZE        2
`define DWC_MST_SIZE_MAX    3
`define DWC_MAX_SLV_BEATS   16
`define DWC_BURST_INCR      2'b01

// decoded request queue, power of two
`define DWC_QUEUE_DEPTH     4

// 0 forces slave ID to zero
`define DWC_READ_INTERLEAVE 1

`endif
